// ==== filelist.f ====
+incdir+.
stream_pkg.sv
traffic_pkg.sv
rand_wait_gen.sv
rand_stream_src.sv
stream_fifo.sv
rand_stream_sink.sv
stream_traffic_top.sv
stream_traffic_props.sv
stream_traffic_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := stream_traffic_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== stream_traffic_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_traffic_tb
  import stream_pkg::*;
  import traffic_pkg::*;
();

  localparam int N_RUNS       = 12;
  localparam int DONE_TIMEOUT = 4000;
  localparam int MID_TIMEOUT  = 1000;
  localparam int IDLE_TIMEOUT = 8;

  logic        clk;
  logic        rst_n;
  logic        start;
  run_cfg_t    cfg;
  logic        busy;
  run_status_t status;

  // Run table, one column per array
  string       run_name [N_RUNS];
  run_cfg_t    run_cfg [N_RUNS];
  run_status_t run_exp [N_RUNS];
  logic        run_mid [N_RUNS];
  int          n_entries;

  logic [31:0] lfsr_state;
  int          n_checks;
  int          n_errors;
  int          n_timeouts;

  stream_traffic_top i_stream_traffic_top (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .start_i  (start),
    .cfg_i    (cfg),
    .busy_o   (busy),
    .status_o (status)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR with x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step for every bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Word the sink should see at beat k, with the optional flip of beat 3
  function automatic data_t ref_word(pattern_e pat, data_t base, int k, logic inject);
    data_t w;
    if (pat == PAT_INCR) begin
      w = base + data_t'(k);
    end else if (pat == PAT_ALT) begin
      w = (k % 2 == 1) ? ~base : base;
    end else begin
      w = base;
    end
    if (inject && k == 3) begin
      w[0] = ~w[0];
    end
    return w;
  endfunction

  task automatic add_run(input string name, input pattern_e pat, input data_t base,
                         input int n, input logic [3:0] max_wait, input logic inject,
                         input logic mid);
    logic [31:0] r;
    run_cfg_t    c;
    run_status_t e;
    c = '0;
    draw_bits(16, r);
    c.src_seed   = r[15:0];
    draw_bits(16, r);
    c.snk_seed   = r[15:0];
    c.pattern    = pat;
    c.base       = base;
    c.n_beats    = beat_cnt_t'(n);
    c.max_wait   = max_wait;
    c.inject_err = inject;
    e.done        = 1'b1;
    e.beat_count  = beat_cnt_t'(n);
    // The flipped beat only exists in runs longer than three beats
    e.error_count = beat_cnt_t'((inject && n > 3) ? 1 : 0);
    e.last_data   = ref_word(pat, base, n - 1, inject);
    run_name[n_entries] = name;
    run_cfg[n_entries]  = c;
    run_exp[n_entries]  = e;
    run_mid[n_entries]  = mid;
    n_entries++;
  endtask

  // Compares done and both counters, last_data has its own check
  task automatic check_status(input string name, input run_status_t exp,
                              input run_status_t act);
    n_checks++;
    if (act.done !== exp.done || act.beat_count !== exp.beat_count ||
        act.error_count !== exp.error_count) begin
      n_errors++;
      $display("CHECK FAILED %s: expected done=%0b beats=%0d errors=%0d, %s", name,
               exp.done, exp.beat_count, exp.error_count,
               $sformatf("actual done=%0b beats=%0d errors=%0d", act.done,
                         act.beat_count, act.error_count));
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected data %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Called on a falling edge, returns one cycle later with start low again
  task automatic pulse_start(input run_cfg_t c);
    cfg   = c;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // The sink drops the old done before the first sample here
  task automatic wait_run_done(output logic reached);
    reached = 1'b0;
    for (int cyc = 0; cyc < DONE_TIMEOUT && !reached; cyc++) begin
      @(negedge clk);
      reached = status.done;
    end
  endtask

  // Busy should drop shortly after done
  task automatic wait_idle();
    for (int cyc = 0; cyc < IDLE_TIMEOUT && busy; cyc++) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_beats(input int min_beats, output logic reached);
    reached = 1'b0;
    for (int cyc = 0; cyc < MID_TIMEOUT && !reached; cyc++) begin
      @(negedge clk);
      reached = (int'(status.beat_count) >= min_beats) && !status.done;
    end
  endtask

  initial begin
    run_cfg_t    alt_cfg;
    logic [31:0] rnd;
    logic        reached;
    rst_n      = 1'b0;
    start      = 1'b0;
    cfg        = '0;
    lfsr_state = 32'h7730;
    n_entries  = 0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;

    add_run("incr_20", PAT_INCR, 16'h1234, 20, 4'd3, 1'b0, 1'b0);
    add_run("const_odd", PAT_CONST, 16'hA5C3, 7, 4'd5, 1'b0, 1'b0);
    add_run("const_even", PAT_CONST, 16'h0001, 10, 4'd2, 1'b0, 1'b0);
    add_run("alt_odd", PAT_ALT, 16'h0F0F, 9, 4'd4, 1'b0, 1'b0);
    add_run("alt_even", PAT_ALT, 16'h8001, 12, 4'd1, 1'b0, 1'b0);
    add_run("inject_8", PAT_INCR, 16'h0100, 8, 4'd2, 1'b1, 1'b0);
    add_run("inject_3", PAT_INCR, 16'h0100, 3, 4'd2, 1'b1, 1'b0);
    // Here the flipped beat is also the last one
    add_run("inject_4", PAT_ALT, 16'h3C3C, 4, 4'd2, 1'b1, 1'b0);
    draw_bits(16, rnd);
    add_run("stress_alt", PAT_ALT, data_t'(rnd[15:0]), 40, 4'd15, 1'b0, 1'b0);
    add_run("stress_wrap", PAT_INCR, 16'hFFF0, 33, 4'd15, 1'b0, 1'b0);
    add_run("mid_start", PAT_INCR, 16'h0500, 16, 4'd7, 1'b0, 1'b1);
    add_run("no_wait", PAT_INCR, 16'h2000, 24, 4'd0, 1'b0, 1'b0);

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("busy after reset", 1'b0, busy);
    check_status("status after reset", '0, status);

    for (int i = 0; i < n_entries; i++) begin
      pulse_start(run_cfg[i]);
      if (run_mid[i]) begin
        wait_beats(4, reached);
        if (!reached) begin
          n_timeouts++;
          $display("Run %s made no progress within %0d cycles", run_name[i], MID_TIMEOUT);
          break;
        end
        check_flag({run_name[i], " busy"}, 1'b1, busy);
        // A different run that the top must drop
        alt_cfg         = run_cfg[i];
        alt_cfg.pattern = PAT_CONST;
        alt_cfg.base    = ~run_cfg[i].base;
        alt_cfg.n_beats = beat_cnt_t'(5);
        pulse_start(alt_cfg);
      end
      wait_run_done(reached);
      if (!reached) begin
        n_timeouts++;
        $display("Run %s did not finish within %0d cycles", run_name[i], DONE_TIMEOUT);
        break;
      end
      check_status(run_name[i], run_exp[i], status);
      check_data({run_name[i], " last_data"}, run_exp[i].last_data, status.last_data);
      wait_idle();
      check_flag({run_name[i], " busy after done"}, 1'b0, busy);
    end

    $display("Checks run %0d, check errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stream_traffic_props.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_consts.svh"

module stream_traffic_props
  import stream_pkg::*;
#(
  parameter int unsigned DEPTH = `STREAM_FIFO_DEPTH
) (
  input wire logic      clk_i,
  input wire logic      rst_ni,
  input wire logic      valid_i,
  input wire logic      ready_i,
  input wire beat_t     beat_i,
  input wire logic      push_i,
  input wire logic      pop_i,
  input wire logic      start_i,
  input wire logic      done_i,
  input wire beat_cnt_t beat_count_i,
  input wire beat_cnt_t n_beats_i
);

  // Beats held in the FIFO, counted from the two handshakes alone
  int unsigned fill_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q <= 0;
    end else begin
      fill_q <= fill_q + 32'(push_i) - 32'(pop_i);
    end
  end

  // An offered beat that is not taken stays on the link unchanged
  hold_until_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !ready_i |=> valid_i && $stable(beat_i))
    else $error("Beat or valid changed before the transfer");

  // A full FIFO only takes a beat when it hands one out in the same cycle
  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && (fill_q == DEPTH) |-> pop_i)
    else $error("FIFO pushed while full");

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (fill_q != 0))
    else $error("FIFO popped while empty");

  // In the start cycle the configuration is already new, but done is still the old one
  done_count_exact: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i && !start_i |-> beat_count_i == n_beats_i)
    else $error("Done with a beat count that differs from n_beats");

endmodule

// FIFO input carries the source link, so stability there covers the source
bind stream_fifo stream_traffic_props #(.DEPTH(DEPTH)) i_fifo_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      (valid_i),
  .ready_i      (ready_o),
  .beat_i       (beat_i),
  .push_i       (push),
  .pop_i        (pop),
  .start_i      (1'b0),
  .done_i       (1'b0),
  .beat_count_i ('0),
  .n_beats_i    ('0)
);

// Sink input is the FIFO output link
bind rand_stream_sink stream_traffic_props i_sink_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      (valid_i),
  .ready_i      (ready_o),
  .beat_i       (beat_i),
  .push_i       (1'b0),
  .pop_i        (1'b0),
  .start_i      (start_i),
  .done_i       (status_o.done),
  .beat_count_i (status_o.beat_count),
  .n_beats_i    (cfg_i.n_beats)
);

`default_nettype wire

// ==== stream_traffic_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_traffic_top
  import stream_pkg::*;
  import traffic_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     start_i,
  input  wire run_cfg_t cfg_i,
  output logic          busy_o,
  output run_status_t   status_o
);

  run_cfg_t cfg_q;
  logic     busy_q;
  logic     start_d_q;
  logic     start_ok;
  beat_t    src_beat;
  logic     src_valid;
  logic     src_ready;
  beat_t    snk_beat;
  logic     snk_valid;
  logic     snk_ready;

  // A start during a run is dropped
  assign start_ok = start_i && !busy_q;

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      cfg_q <= cfg_i;
    end
  end

  // Source and sink start one cycle later, from the latched configuration
  // The old done is still visible in that cycle and must not end the new run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      start_d_q <= 1'b0;
    end else begin
      start_d_q <= start_ok;
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (status_o.done && !start_d_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign busy_o = busy_q;

  rand_stream_src i_rand_stream_src (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_d_q),
    .cfg_i   (cfg_q),
    .beat_o  (src_beat),
    .valid_o (src_valid),
    .ready_i (src_ready)
  );

  stream_fifo i_stream_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .beat_i  (src_beat),
    .valid_i (src_valid),
    .ready_o (src_ready),
    .beat_o  (snk_beat),
    .valid_o (snk_valid),
    .ready_i (snk_ready)
  );

  rand_stream_sink i_rand_stream_sink (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_d_q),
    .cfg_i    (cfg_q),
    .beat_i   (snk_beat),
    .valid_i  (snk_valid),
    .ready_o  (snk_ready),
    .status_o (status_o)
  );

endmodule

`default_nettype wire

// ==== rand_stream_sink.sv ====
`timescale 1ns/10ps
`default_nettype none

module rand_stream_sink
  import stream_pkg::*;
  import traffic_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     start_i,
  input  wire run_cfg_t cfg_i,
  input  wire beat_t    beat_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  output run_status_t   status_o
);

  snk_state_e state_q;
  beat_cnt_t  beat_cnt_q;
  beat_cnt_t  beat_cnt_nxt;
  beat_cnt_t  err_cnt_q;
  data_t      last_q;
  data_t      expected;
  logic       strobe;
  logic       xfer;
  logic       mismatch;

  // Random ready gaps
  // Each strobe is taken after one cycle, whether or not a beat was there
  rand_wait_gen i_rand_wait_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (start_i),
    .seed_i     (cfg_i.snk_seed),
    .max_wait_i (cfg_i.max_wait),
    .ack_i      (ready_o),
    .strobe_o   (strobe)
  );

  assign ready_o = strobe && (state_q == SNK_RUN);
  assign xfer    = valid_i && ready_o;

  // Compare against the rule at the index the beat carries
  assign expected     = pattern_data(cfg_i.pattern, cfg_i.base, beat_i.index);
  assign mismatch     = (beat_i.data != expected);
  assign beat_cnt_nxt = beat_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SNK_IDLE;
      beat_cnt_q <= '0;
      err_cnt_q  <= '0;
      last_q     <= '0;
    end else if (start_i) begin
      beat_cnt_q <= '0;
      err_cnt_q  <= '0;
      last_q     <= '0;
      // An empty run is finished at once
      state_q    <= (cfg_i.n_beats == '0) ? SNK_DONE : SNK_RUN;
    end else begin
      case (state_q)
        SNK_RUN: begin
          if (xfer) begin
            beat_cnt_q <= beat_cnt_nxt;
            last_q     <= beat_i.data;
            if (mismatch) begin
              err_cnt_q <= err_cnt_q + 1'b1;
            end
            // Done shows up the cycle after the last beat
            if (beat_cnt_nxt == cfg_i.n_beats) begin
              state_q <= SNK_DONE;
            end
          end
        end
        // Idle and done wait for the next start
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  assign status_o = '{
    done:        (state_q == SNK_DONE),
    beat_count:  beat_cnt_q,
    error_count: err_cnt_q,
    last_data:   last_q
  };

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_consts.svh"

module stream_fifo
  import stream_pkg::*;
#(
  parameter int unsigned DEPTH = `STREAM_FIFO_DEPTH
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire beat_t beat_i,
  input  wire logic  valid_i,
  output logic       ready_o,
  output beat_t      beat_o,
  output logic       valid_o,
  input  wire logic  ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  beat_t        mem_q [DEPTH];
  ptr_t         wptr_q;
  ptr_t         rptr_q;
  logic [PTR_W:0] cnt_q;
  logic         full;
  logic         push;
  logic         pop;

  assign full = (cnt_q == (PTR_W+1)'(DEPTH));

  // A full FIFO still takes a beat in the cycle it hands one out
  assign ready_o = !full || ready_i;
  // Data written on an edge is visible the next cycle
  assign valid_o = (cnt_q != '0);
  assign beat_o  = mem_q[rptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= beat_i;
    end
  end

  // Pointers wrap explicitly at DEPTH
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == ptr_t'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == ptr_t'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

endmodule

`default_nettype wire

// ==== rand_stream_src.sv ====
`timescale 1ns/10ps
`default_nettype none

module rand_stream_src
  import stream_pkg::*;
  import traffic_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     start_i,
  input  wire run_cfg_t cfg_i,
  output beat_t         beat_o,
  output logic          valid_o,
  input  wire logic     ready_i
);

  beat_cnt_t idx_q;
  beat_cnt_t remain_q;
  logic      strobe;
  logic      xfer;
  data_t     data;

  // Random gaps between offered beats
  // The strobe is only consumed by a real transfer
  rand_wait_gen i_rand_wait_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (start_i),
    .seed_i     (cfg_i.src_seed),
    .max_wait_i (cfg_i.max_wait),
    .ack_i      (xfer),
    .strobe_o   (strobe)
  );

  // Valid comes from registers only, so it cannot drop before the transfer
  assign valid_o = strobe && (remain_q != '0);
  assign xfer    = valid_o && ready_i;

  always_comb begin
    data = pattern_data(cfg_i.pattern, cfg_i.base, idx_q);
    // Index 3 only exists when n_beats exceeds 3
    if (cfg_i.inject_err && (idx_q == beat_cnt_t'(3))) begin
      data[0] = ~data[0];
    end
  end

  // The beat only changes after a transfer, so it is stable while valid
  assign beat_o = '{data: data, index: idx_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q    <= '0;
      remain_q <= '0;
    end else if (start_i) begin
      idx_q    <= '0;
      remain_q <= cfg_i.n_beats;
    end else if (xfer) begin
      idx_q    <= idx_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rand_wait_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_consts.svh"

module rand_wait_gen
  import traffic_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  load_i,
  input  wire seed_t seed_i,
  input  wire wait_t max_wait_i,
  input  wire logic  ack_i,
  output logic       strobe_o
);

  localparam int LFSR_W = `WAIT_LFSR_W;
  // Feedback mask for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [LFSR_W-1:0] TAPS = LFSR_W'(16'hB400);
  // Used in place of an all-zero seed, which would lock the LFSR
  localparam logic [LFSR_W-1:0] SEED_ALT = LFSR_W'(16'hACE1);

  seed_t lfsr_q;
  seed_t lfsr_src;
  seed_t lfsr_nxt;
  wait_t cnt_q;
  wait_t draw;
  logic  strobe_q;
  logic  active_q;
  logic  redraw;

  // A load restarts from the seed, any other draw continues the sequence
  assign lfsr_src = load_i ? ((seed_i == '0) ? SEED_ALT : seed_i) : lfsr_q;
  assign lfsr_nxt = {1'b0, lfsr_src[LFSR_W-1:1]} ^ (lfsr_src[0] ? TAPS : '0);

  // Number of idle cycles, 0 to max_wait_i
  assign draw = wait_t'({1'b0, lfsr_nxt[3:0]} % ({1'b0, max_wait_i} + 5'd1));

  // A new wait is drawn on load and whenever the user takes the strobe
  assign redraw = load_i || (strobe_q && ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= '0;
      cnt_q    <= '0;
      strobe_q <= 1'b0;
      active_q <= 1'b0;
    end else if (redraw) begin
      lfsr_q   <= lfsr_nxt;
      active_q <= 1'b1;
      // Zero idle cycles keeps the strobe up back to back
      strobe_q <= (draw == '0);
      cnt_q    <= (draw == '0) ? '0 : draw - 1'b1;
    end else if (active_q && !strobe_q) begin
      // Count down the idle gap, then offer the strobe
      if (cnt_q == '0) begin
        strobe_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Held high until acknowledged
  assign strobe_o = strobe_q;

endmodule

`default_nettype wire

// ==== traffic_pkg.sv ====
`default_nettype none

`include "stream_consts.svh"

package traffic_pkg;

  import stream_pkg::*;

  // Seed for one random wait generator
  typedef logic [`WAIT_LFSR_W-1:0] seed_t;

  // Upper bound of idle cycles between two strobes
  typedef logic [3:0] wait_t;

  // Everything a run needs, latched by the top on start
  typedef struct packed {
    pattern_e  pattern;
    data_t     base;
    beat_cnt_t n_beats;
    seed_t     src_seed;
    seed_t     snk_seed;
    wait_t     max_wait;
    // Flips bit 0 of beat 3 in the source
    logic      inject_err;
  } run_cfg_t;

  // Result of a run as seen by the sink
  typedef struct packed {
    logic      done;
    beat_cnt_t beat_count;
    beat_cnt_t error_count;
    data_t     last_data;
  } run_status_t;

  // Sink FSM states
  typedef enum logic [1:0] {
    SNK_IDLE = 2'd0,
    SNK_RUN  = 2'd1,
    SNK_DONE = 2'd2
  } snk_state_e;

endpackage

`default_nettype wire

// ==== stream_pkg.sv ====
`default_nettype none

`include "stream_consts.svh"

package stream_pkg;

  // One data word carried by the stream
  typedef logic [`STREAM_DATA_W-1:0] data_t;

  // Beat index within a run, also used for all beat counters
  typedef logic [`BEAT_CNT_W-1:0] beat_cnt_t;

  // One transfer together with its position in the run
  typedef struct packed {
    data_t     data;
    beat_cnt_t index;
  } beat_t;

  // Data pattern that the source sends and the sink expects
  typedef enum logic [1:0] {
    PAT_INCR  = 2'd0,
    PAT_CONST = 2'd1,
    PAT_ALT   = 2'd2
  } pattern_e;

  // Expected word for beat idx, shared by source and sink
  function automatic data_t pattern_data(pattern_e pattern, data_t base, beat_cnt_t idx);
    data_t word;
    case (pattern)
      // Wraps modulo the data width
      PAT_INCR: word = data_t'(base + data_t'(idx));
      // Odd beats carry the inverse of the base word
      PAT_ALT:  word = idx[0] ? ~base : base;
      default:  word = base;
    endcase
    return word;
  endfunction

endpackage

`default_nettype wire

// ==== stream_consts.svh ====
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Width of one data word on the stream
`define STREAM_DATA_W 16

// Default number of entries in the FIFO under test
`define STREAM_FIFO_DEPTH 4

// Width of the Galois LFSR inside each random wait generator
`define WAIT_LFSR_W 16

// Width of the beat index and of the beat and error counters
`define BEAT_CNT_W 16

`endif
